// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module axi_wr_path_tb \
		--Mdir obj_dir -f flist.f
	./obj_dir/Vaxi_wr_path_tb

clean:
	rm -rf obj_dir

// ==== flist.f ====
logic/axi_defs_pkg.sv
logic/mem_defs_pkg.sv
logic/wr_cmd_if.sv
logic/sync_fifo.sv
logic/packet_fifo.sv
logic/wr_accept_fsm.sv
logic/burst_chunker.sv
logic/axi_wr_path.sv
verification/axi_wr_path_tb.sv

// ==== logic/axi_defs_pkg.sv ====
`default_nettype none

package axi_defs_pkg;

  // width of the AXI4 burst length field
  localparam int AXLEN_BITS = 8;

  // AXI4 burst types, only INCR is handled by the write path
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // AXI4 write response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

endpackage

`default_nettype wire

// ==== logic/axi_wr_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_wr_path #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int CMD_DEPTH  = 16,
  parameter int DATA_DEPTH = 512
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                axi_awvalid_i,
  output logic                                axi_awready_o,
  input  logic [ADDR_WIDTH-1:0]               axi_awaddr_i,
  input  logic [ID_WIDTH-1:0]                 axi_awid_i,
  input  logic [axi_defs_pkg::AXLEN_BITS-1:0] axi_awlen_i,
  input  axi_defs_pkg::burst_e                axi_awburst_i,
  input  logic                                axi_wvalid_i,
  output logic                                axi_wready_o,
  input  logic [DATA_WIDTH-1:0]               axi_wdata_i,
  input  logic [DATA_WIDTH/8-1:0]             axi_wstrb_i,
  input  logic                                axi_wlast_i,
  output logic                                axi_bvalid_o,
  input  logic                                axi_bready_i,
  output axi_defs_pkg::resp_e                 axi_bresp_o,
  output logic [ID_WIDTH-1:0]                 axi_bid_o,
  output logic                                mem_store_o,
  input  logic                                mem_accept_i,
  output logic                                mem_wseq_o,
  output logic [ID_WIDTH-1:0]                 mem_wrid_o,
  output logic [ADDR_WIDTH-1:0]               mem_addr_o,
  output logic                                mem_valid_o,
  input  logic                                mem_ready_i,
  output logic                                mem_last_o,
  output logic [DATA_WIDTH/8-1:0]             mem_strb_o,
  output logic [DATA_WIDTH-1:0]               mem_data_o
);

  // command word is {addr, id, seq}, data word is {strobes, data}
  localparam int CMD_WIDTH  = ADDR_WIDTH + ID_WIDTH + 1;
  localparam int WORD_WIDTH = DATA_WIDTH + DATA_WIDTH / 8;

  logic burst_start;
  logic chunk_ready;
  logic data_ready;
  logic data_push;
  logic mem_last_taken;

  wr_cmd_if #(.ADDR_WIDTH(ADDR_WIDTH), .ID_WIDTH(ID_WIDTH)) cmd_bus ();

  assign data_push      = axi_wvalid_i & axi_wready_o;
  assign mem_last_taken = mem_valid_o & mem_ready_i & mem_last_o;

  // axi_awburst_i is not decoded, every burst is taken as INCR
  wr_accept_fsm #(.ID_WIDTH(ID_WIDTH), .CMD_DEPTH(CMD_DEPTH)) u_fsm (
    .clock(clock), .reset(reset),
    .awvalid_i(axi_awvalid_i), .wvalid_i(axi_wvalid_i), .wlast_i(axi_wlast_i),
    .bready_i(axi_bready_i), .chunk_ready_i(chunk_ready), .data_ready_i(data_ready),
    .mem_last_taken_i(mem_last_taken), .awid_i(axi_awid_i),
    .awready_o(axi_awready_o), .wready_o(axi_wready_o), .bvalid_o(axi_bvalid_o),
    .bresp_o(axi_bresp_o), .bid_o(axi_bid_o), .burst_start_o(burst_start)
  );

  burst_chunker #(.ADDR_WIDTH(ADDR_WIDTH), .ID_WIDTH(ID_WIDTH)) u_chunker (
    .clock(clock), .reset(reset), .start_i(burst_start), .len_i(axi_awlen_i),
    .id_i(axi_awid_i), .addr_i(axi_awaddr_i), .ready_o(chunk_ready), .cmd(cmd_bus)
  );

  sync_fifo #(.WIDTH(CMD_WIDTH), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
    .clock(clock), .reset(reset),
    .valid_i(cmd_bus.valid), .ready_o(cmd_bus.ready),
    .data_i({cmd_bus.addr, cmd_bus.id, cmd_bus.seq}),
    .valid_o(mem_store_o), .ready_i(mem_accept_i),
    .data_o({mem_addr_o, mem_wrid_o, mem_wseq_o})
  );

  packet_fifo #(.WIDTH(WORD_WIDTH), .DEPTH(DATA_DEPTH)) u_data_fifo (
    .clock(clock), .reset(reset),
    .valid_i(data_push), .ready_o(data_ready), .last_i(axi_wlast_i),
    .data_i({axi_wstrb_i, axi_wdata_i}),
    .valid_o(mem_valid_o), .ready_i(mem_ready_i), .last_o(mem_last_o),
    .data_o({mem_strb_o, mem_data_o})
  );

endmodule

`default_nettype wire

// ==== logic/burst_chunker.sv ====
`timescale 1ns/10ps
`default_nettype none

module burst_chunker #(
  parameter int ADDR_WIDTH = 32,
  parameter int ID_WIDTH   = 4
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                start_i,
  input  logic [axi_defs_pkg::AXLEN_BITS-1:0] len_i,
  input  logic [ID_WIDTH-1:0]                 id_i,
  input  logic [ADDR_WIDTH-1:0]               addr_i,
  output logic                                ready_o,
  wr_cmd_if.source                            cmd
);

  localparam int LEN_BITS   = axi_defs_pkg::AXLEN_BITS;
  localparam int BEAT_SHIFT = $clog2(mem_defs_pkg::CHUNK_BEATS);
  // enough bits for a full 256-beat burst in chunks
  localparam int CNT_BITS   = LEN_BITS + 1 - BEAT_SHIFT;

  logic [LEN_BITS:0]       beats;
  logic [CNT_BITS-1:0]     chunks;
  logic [CNT_BITS-1:0]     remain_q;
  logic                    valid_q;
  mem_defs_pkg::seq_e      seq_q;
  logic [ID_WIDTH-1:0]     id_q;
  logic [ADDR_WIDTH-1:0]   addr_q;
  logic                    cmd_fire;

  // awlen + 1 beats, split into groups of four
  assign beats  = {1'b0, len_i} + 1'b1;
  assign chunks = CNT_BITS'(beats >> BEAT_SHIFT);

  assign cmd_fire = valid_q & cmd.ready;
  assign ready_o  = ~valid_q;

  assign cmd.valid = valid_q;
  assign cmd.seq   = seq_q;
  assign cmd.id    = id_q;
  assign cmd.addr  = addr_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q  <= 1'b0;
      remain_q <= '0;
    end else if (start_i && !valid_q) begin
      valid_q  <= 1'b1;
      remain_q <= chunks - 1'b1;
    end else if (cmd_fire) begin
      if (remain_q == '0) begin
        valid_q <= 1'b0;
      end else begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  // command payload, stepped after each accepted chunk
  always_ff @(posedge clock) begin
    if (start_i && !valid_q) begin
      seq_q  <= mem_defs_pkg::CHUNK_FIRST;
      id_q   <= id_i;
      addr_q <= addr_i;
    end else if (cmd_fire && remain_q != '0) begin
      seq_q  <= mem_defs_pkg::CHUNK_NEXT;
      addr_q <= addr_q + ADDR_WIDTH'(mem_defs_pkg::CHUNK_BYTES);
    end
  end

endmodule

`default_nettype wire

// ==== logic/mem_defs_pkg.sv ====
`default_nettype none

package mem_defs_pkg;

  // one BL8 chunk is four 32-bit AXI beats
  localparam int CHUNK_BEATS = 4;

  // address step from one chunk to the next
  localparam int CHUNK_BYTES = 16;

  // position of a chunk within its burst
  typedef enum logic {
    CHUNK_FIRST = 1'b0,
    CHUNK_NEXT  = 1'b1
  } seq_e;

endpackage

`default_nettype wire

// ==== logic/packet_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module packet_fifo #(
  parameter int WIDTH = 36,
  parameter int DEPTH = 512
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic             last_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic             last_o,
  output logic [WIDTH-1:0] data_o
);

  localparam int ABITS = $clog2(DEPTH);

  // each word keeps its last flag in the top bit
  logic [WIDTH:0] mem [DEPTH];
  logic [WIDTH:0] rd_word;
  logic [ABITS:0] wr_ptr;
  logic [ABITS:0] commit_ptr;
  logic [ABITS:0] rd_ptr;
  logic           push;
  logic           pop;

  // room is measured against the read pointer, not the commit point
  assign ready_o = (wr_ptr ^ rd_ptr) != {1'b1, {ABITS{1'b0}}};

  // the read side only sees words up to the last committed packet
  assign valid_o = commit_ptr != rd_ptr;

  assign rd_word = mem[rd_ptr[ABITS-1:0]];
  assign last_o  = rd_word[WIDTH];
  assign data_o  = rd_word[WIDTH-1:0];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // a packet is released once its last word is stored
  always_ff @(posedge clock) begin
    if (reset) begin
      commit_ptr <= '0;
    end else if (push && last_i) begin
      commit_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr[ABITS-1:0]] <= {last_i, data_i};
    end
  end

endmodule

`default_nettype wire

// ==== logic/sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // DEPTH is a power of two, pointers carry one wrap bit
  localparam int ABITS = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [ABITS:0]   wr_ptr;
  logic [ABITS:0]   rd_ptr;
  logic             push;
  logic             pop;

  assign ready_o = (wr_ptr ^ rd_ptr) != {1'b1, {ABITS{1'b0}}};
  assign valid_o = wr_ptr != rd_ptr;
  assign data_o  = mem[rd_ptr[ABITS-1:0]];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr[ABITS-1:0]] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/wr_accept_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module wr_accept_fsm #(
  parameter int ID_WIDTH  = 4,
  parameter int CMD_DEPTH = 16
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                awvalid_i,
  input  logic                wvalid_i,
  input  logic                wlast_i,
  input  logic                bready_i,
  input  logic                chunk_ready_i,
  input  logic                data_ready_i,
  input  logic                mem_last_taken_i,
  input  logic [ID_WIDTH-1:0] awid_i,
  output logic                awready_o,
  output logic                wready_o,
  output logic                bvalid_o,
  output axi_defs_pkg::resp_e bresp_o,
  output logic [ID_WIDTH-1:0] bid_o,
  output logic                burst_start_o
);

  // at most CMD_DEPTH bursts wait in the id FIFO
  localparam int PEND_BITS = $clog2(CMD_DEPTH + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_FILL, ST_BUSY} state_e;

  state_e               state;
  logic                 awready_q;
  logic                 wready_q;
  logic                 bvalid_q;
  logic                 w_last_fire;
  logic                 b_fire;
  logic                 id_ready;
  logic [PEND_BITS-1:0] pend_q;
  logic [PEND_BITS-1:0] pend_next;

  assign awready_o     = awready_q;
  // a full data FIFO stalls the W channel
  assign wready_o      = wready_q & data_ready_i;
  assign bvalid_o      = bvalid_q;
  assign bresp_o       = axi_defs_pkg::OKAY;
  assign burst_start_o = awvalid_i & awready_q;
  assign w_last_fire   = wvalid_i & wready_o & wlast_i;
  assign b_fire        = bvalid_q & bready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ST_IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (burst_start_o) begin
            state     <= ST_FILL;
            awready_q <= 1'b0;
            wready_q  <= 1'b1;
          end else begin
            awready_q <= 1'b1;
          end
        end
        ST_FILL: begin
          if (w_last_fire) begin
            state    <= ST_BUSY;
            wready_q <= 1'b0;
          end
        end
        ST_BUSY: begin
          // wait for room in every block before the next address
          if (chunk_ready_i && data_ready_i && id_ready) begin
            state     <= ST_IDLE;
            awready_q <= 1'b1;
          end
        end
        default: begin
          state     <= ST_IDLE;
          awready_q <= 1'b0;
          wready_q  <= 1'b0;
        end
      endcase
    end
  end

  // completed bursts still waiting for their response
  always_comb begin
    pend_next = pend_q + PEND_BITS'(mem_last_taken_i) - PEND_BITS'(b_fire);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pend_q   <= '0;
      bvalid_q <= 1'b0;
    end else begin
      pend_q   <= pend_next;
      bvalid_q <= (pend_next != '0);
    end
  end

  // ids in burst order, the head answers the oldest burst
  sync_fifo #(
    .WIDTH(ID_WIDTH),
    .DEPTH(CMD_DEPTH)
  ) u_id_fifo (
    .clock  (clock),
    .reset  (reset),
    .valid_i(burst_start_o),
    .ready_o(id_ready),
    .data_i (awid_i),
    .valid_o(),
    .ready_i(b_fire),
    .data_o (bid_o)
  );

endmodule

`default_nettype wire

// ==== logic/wr_cmd_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// chunk commands from the chunker into the command FIFO
interface wr_cmd_if #(
  parameter int ADDR_WIDTH = 32,
  parameter int ID_WIDTH   = 4
);

  logic                  valid;
  logic                  ready;
  mem_defs_pkg::seq_e    seq;
  logic [ID_WIDTH-1:0]   id;
  logic [ADDR_WIDTH-1:0] addr;

  // payload is held until valid && ready
  modport source (output valid, output seq, output id, output addr, input ready);

  modport sink (input valid, input seq, input id, input addr, output ready);

endinterface

`default_nettype wire

// ==== verification/axi_wr_path_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_wr_path_tb;

  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 32;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int ID_WIDTH        = 4;
  localparam int NUM_BURSTS      = 40;
  localparam int BEATS_PER_CHUNK = 4;
  localparam int CHUNK_STEP      = 16;
  localparam int TIMEOUT_CYCLES  = NUM_BURSTS * 64 * 8 + 500;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [ID_WIDTH-1:0]   id;
    mem_defs_pkg::seq_e    seq;
  } cmd_t;

  typedef struct packed {
    logic                  last;
    logic [STRB_WIDTH-1:0] strb;
    logic [DATA_WIDTH-1:0] data;
  } beat_t;

  logic                  clock;
  logic                  reset;
  logic                  axi_awvalid_i;
  logic                  axi_awready_o;
  logic [ADDR_WIDTH-1:0] axi_awaddr_i;
  logic [ID_WIDTH-1:0]   axi_awid_i;
  logic [7:0]            axi_awlen_i;
  axi_defs_pkg::burst_e  axi_awburst_i;
  logic                  axi_wvalid_i;
  logic                  axi_wready_o;
  logic [DATA_WIDTH-1:0] axi_wdata_i;
  logic [STRB_WIDTH-1:0] axi_wstrb_i;
  logic                  axi_wlast_i;
  logic                  axi_bvalid_o;
  logic                  axi_bready_i;
  axi_defs_pkg::resp_e   axi_bresp_o;
  logic [ID_WIDTH-1:0]   axi_bid_o;
  logic                  mem_store_o;
  logic                  mem_accept_i;
  logic                  mem_wseq_o;
  logic [ID_WIDTH-1:0]   mem_wrid_o;
  logic [ADDR_WIDTH-1:0] mem_addr_o;
  logic                  mem_valid_o;
  logic                  mem_ready_i;
  logic                  mem_last_o;
  logic [STRB_WIDTH-1:0] mem_strb_o;
  logic [DATA_WIDTH-1:0] mem_data_o;

  integer seed;
  int     cycle_count;
  // beats written on W, and the running total at the latest wlast
  int     w_beats;
  int     done_beats;
  int     taken_beats;
  logic   b_waiting;

  cmd_t                exp_cmd_q[$];
  beat_t               exp_beat_q[$];
  logic [ID_WIDTH-1:0] exp_id_q[$];

  axi_wr_path UUT (.*);

  always #2 clock = ~clock;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR %s: expected %h, got %h", name, exp, got));
    end
  endtask

  task automatic check_cmd(input cmd_t exp, input logic [ADDR_WIDTH-1:0] got_addr,
                           input logic [ID_WIDTH-1:0] got_id, input mem_defs_pkg::seq_e got_seq);
    if (got_addr !== exp.addr) begin
      fail_run($sformatf("ERR mem_addr_o: expected %h, got %h", exp.addr, got_addr));
    end
    if (got_id !== exp.id) begin
      fail_run($sformatf("ERR mem_wrid_o: expected %h, got %h", exp.id, got_id));
    end
    if (got_seq !== exp.seq) begin
      fail_run($sformatf("ERR mem_wseq_o: expected %h, got %h", exp.seq, got_seq));
    end
  endtask

  task automatic check_beat(input beat_t exp, input logic got_last,
                            input logic [STRB_WIDTH-1:0] got_strb,
                            input logic [DATA_WIDTH-1:0] got_data);
    if (got_data !== exp.data) begin
      fail_run($sformatf("ERR mem_data_o: expected %h, got %h", exp.data, got_data));
    end
    if (got_strb !== exp.strb) begin
      fail_run($sformatf("ERR mem_strb_o: expected %h, got %h", exp.strb, got_strb));
    end
    if (got_last !== exp.last) begin
      fail_run($sformatf("ERR mem_last_o: expected %h, got %h", exp.last, got_last));
    end
  endtask

  task automatic check_resp(input logic [ID_WIDTH-1:0] exp_id,
                            input axi_defs_pkg::resp_e got_resp,
                            input logic [ID_WIDTH-1:0] got_id);
    if (got_resp !== axi_defs_pkg::OKAY) begin
      fail_run($sformatf("ERR axi_bresp_o: expected %h, got %h", axi_defs_pkg::OKAY, got_resp));
    end
    if (got_id !== exp_id) begin
      fail_run($sformatf("ERR axi_bid_o: expected %h, got %h", exp_id, got_id));
    end
  endtask

  // one command per four beats, address stepping by 16 bytes
  task automatic expect_burst(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [ID_WIDTH-1:0] id, input logic [7:0] len);
    cmd_t c;
    int   chunks;
    int   k;
    chunks = (int'(len) + 1) / BEATS_PER_CHUNK;
    for (k = 0; k < chunks; k++) begin
      c.addr = addr + ADDR_WIDTH'(CHUNK_STEP * k);
      c.id   = id;
      c.seq  = (k == 0) ? mem_defs_pkg::CHUNK_FIRST : mem_defs_pkg::CHUNK_NEXT;
      exp_cmd_q.push_back(c);
    end
    exp_id_q.push_back(id);
  endtask

  // advance one cycle and redraw the memory and B back-pressure
  task automatic next_cycle();
    @(posedge clock);
    #1;
    mem_accept_i = ($random(seed) & 3) != 0;
    mem_ready_i  = ($random(seed) & 3) != 0;
    axi_bready_i = ($random(seed) & 1) != 0;
  endtask

  task automatic run_burst();
    int   beats;
    int   b;
    logic taken;
    beats = BEATS_PER_CHUNK * (($random(seed) & 15) + 1);
    while (($random(seed) & 3) == 0) next_cycle();
    axi_awvalid_i = 1'b1;
    axi_awaddr_i  = $random(seed) & 32'hffff_fff0;
    axi_awid_i    = ID_WIDTH'($random(seed));
    axi_awlen_i   = 8'(beats - 1);
    axi_awburst_i = axi_defs_pkg::INCR;
    do begin
      @(negedge clock);
      taken = axi_awready_o;
      next_cycle();
    end while (!taken);
    axi_awvalid_i = 1'b0;
    for (b = 0; b < beats; b++) begin
      while (($random(seed) & 3) == 0) next_cycle();
      axi_wvalid_i = 1'b1;
      axi_wdata_i  = DATA_WIDTH'($random(seed));
      axi_wstrb_i  = STRB_WIDTH'($random(seed));
      axi_wlast_i  = (b == beats - 1);
      do begin
        @(negedge clock);
        taken = axi_wready_o;
        next_cycle();
      end while (!taken);
      axi_wvalid_i = 1'b0;
      axi_wlast_i  = 1'b0;
    end
  endtask

  // model and checks, sampled at the falling edge where all signals are settled
  always @(negedge clock) begin : monitor
    cmd_t                exp_cmd;
    beat_t               exp_beat;
    logic [ID_WIDTH-1:0] exp_id;
    if (!reset) begin
      if (axi_awvalid_i && axi_awready_o) begin
        expect_burst(axi_awaddr_i, axi_awid_i, axi_awlen_i);
      end
      if (mem_store_o && mem_accept_i) begin
        if (exp_cmd_q.size() == 0) fail_run("memory command issued with no chunk outstanding");
        exp_cmd = exp_cmd_q.pop_front();
        check_cmd(exp_cmd, mem_addr_o, mem_wrid_o, mem_defs_pkg::seq_e'(mem_wseq_o));
      end
      // a beat taken now must belong to a burst finished on an earlier edge
      if (mem_valid_o && mem_ready_i) begin
        taken_beats++;
        if (taken_beats > done_beats) fail_run("data beat released before its burst completed");
        if (exp_beat_q.size() == 0) fail_run("memory data beat with no beat outstanding");
        exp_beat = exp_beat_q.pop_front();
        check_beat(exp_beat, mem_last_o, mem_strb_o, mem_data_o);
      end
      if (axi_wvalid_i && axi_wready_o) begin
        exp_beat_q.push_back({axi_wlast_i, axi_wstrb_i, axi_wdata_i});
        w_beats++;
        if (axi_wlast_i) done_beats = w_beats;
      end
      if (b_waiting && !axi_bvalid_o) fail_run("bvalid dropped before bready was seen");
      if (axi_bvalid_o && axi_bready_i) begin
        if (exp_id_q.size() == 0) fail_run("write response with no burst outstanding");
        exp_id = exp_id_q.pop_front();
        check_resp(exp_id, axi_bresp_o, axi_bid_o);
      end
      b_waiting = axi_bvalid_o && !axi_bready_i;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) fail_run("timeout: the bursts did not drain in time");
  end

  initial begin
    int n;
    seed          = 32'h781f;
    cycle_count   = 0;
    w_beats       = 0;
    done_beats    = 0;
    taken_beats   = 0;
    b_waiting     = 1'b0;
    clock         = 1'b0;
    reset         = 1'b1;
    axi_awvalid_i = 1'b0;
    axi_awaddr_i  = '0;
    axi_awid_i    = '0;
    axi_awlen_i   = '0;
    axi_awburst_i = axi_defs_pkg::INCR;
    axi_wvalid_i  = 1'b0;
    axi_wdata_i   = '0;
    axi_wstrb_i   = '0;
    axi_wlast_i   = 1'b0;
    axi_bready_i  = 1'b0;
    mem_accept_i  = 1'b0;
    mem_ready_i   = 1'b0;
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;
    @(negedge clock);
    check_flag("axi_awready_o", axi_awready_o, 1'b0);
    check_flag("axi_wready_o", axi_wready_o, 1'b0);
    check_flag("axi_bvalid_o", axi_bvalid_o, 1'b0);
    check_flag("mem_store_o", mem_store_o, 1'b0);
    check_flag("mem_valid_o", mem_valid_o, 1'b0);
    next_cycle();
    for (n = 0; n < NUM_BURSTS; n++) run_burst();
    while (exp_cmd_q.size() != 0 || exp_beat_q.size() != 0 || exp_id_q.size() != 0) begin
      next_cycle();
    end
    repeat (20) next_cycle();
    if (axi_bvalid_o || mem_store_o || mem_valid_o) begin
      fail_run("outputs still active after every burst was answered");
    end else begin
      $display("All tests passed");
    end
    $finish;
  end

endmodule

`default_nettype wire
